// ==== src/conv_pkg.sv ====
package conv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word widths
	localparam int DATA_WIDTH = 8;
	localparam int ACC_WIDTH  = 24;

	// Right shift on the channel sum before clamping
	localparam int FRAC_BITS = 4;

	// Largest supported kernel and its window size
	localparam int KERNEL_MAX = 3;
	localparam int TAPS       = KERNEL_MAX * KERNEL_MAX;

	////////////////////////////////////////////////////////////////////////////
	// Data types
	typedef logic        [DATA_WIDTH-1:0] pixel_t;
	typedef logic signed [DATA_WIDTH-1:0] weight_t;
	typedef logic signed [ACC_WIDTH-1:0]  acc_t;

	// One channel window, row-major, newest pixel in the top tap
	typedef struct packed {
		pixel_t [TAPS-1:0] taps;
		logic   [3:0]      channel;
		logic              last;
	} window_t;

endpackage

// ==== src/conv_weight_regs.sv ====
`timescale 1ns/1ps

module conv_weight_regs #(
	parameter int KERNEL         = 3,
	parameter int CHANNEL_NUM_IN = 2
) (
	input  logic                                                  clk,
	input  logic                                                  reset,
	input  logic                                                  weight_valid,
	input  conv_pkg::weight_t                                     weight_in,
	output conv_pkg::weight_t [CHANNEL_NUM_IN*KERNEL*KERNEL-1:0] weights,
	output logic                                                  weights_ready
);

	// Channel-major, then row, then column
	localparam int WEIGHT_NUM = CHANNEL_NUM_IN * KERNEL * KERNEL;
	localparam int IDX_W      = $clog2(WEIGHT_NUM + 1);

	logic [IDX_W-1:0] wr_idx;
	logic             last_idx;

	// Final slot of the bank
	assign last_idx = (wr_idx == IDX_W'(WEIGHT_NUM - 1));

	// Weight bank, written in place on every strobe
	always_ff @(posedge clk) begin
		if (weight_valid) begin
			weights[wr_idx] <= weight_in;
		end
	end

	// Write index and ready flag
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_idx        <= '0;
			weights_ready <= 1'b0;
		end else if (weight_valid) begin
			if (last_idx) begin
				wr_idx        <= '0;
				weights_ready <= 1'b1;
			end else begin
				// Bank is partial again while a reload is under way
				wr_idx        <= wr_idx + 1'b1;
				weights_ready <= 1'b0;
			end
		end
	end

endmodule

// ==== src/conv_window.sv ====
`timescale 1ns/1ps

module conv_window #(
	parameter int KERNEL         = 3,
	parameter int IMAGE_WIDTH    = 6,
	parameter int IMAGE_HEIGHT   = 6,
	parameter int CHANNEL_NUM_IN = 2
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              pxl_valid,
	input  conv_pkg::pixel_t  pxl_in,
	output conv_pkg::window_t win,
	output logic              win_valid
);

	////////////////////////////////////////////////////////////////////////////
	// Geometry
	localparam int CHAIN_LEN = (KERNEL - 1) * IMAGE_WIDTH * CHANNEL_NUM_IN
		+ KERNEL * CHANNEL_NUM_IN;
	localparam int CH_W  = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
	localparam int COL_W = $clog2(IMAGE_WIDTH);
	localparam int ROW_W = $clog2(IMAGE_HEIGHT);

	// Window struct only holds KERNEL_MAX squared taps
	if (KERNEL > conv_pkg::KERNEL_MAX) begin : g_kernel_check
		$error("conv_window: KERNEL larger than KERNEL_MAX");
	end

	conv_pkg::pixel_t chain [CHAIN_LEN];
	wire conv_pkg::pixel_t [conv_pkg::TAPS-1:0] taps_next;

	logic [CH_W-1:0]  chan_cnt;
	logic [COL_W-1:0] col_cnt;
	logic [ROW_W-1:0] row_cnt;
	logic             chan_last;
	logic             col_last;
	logic             row_last;
	logic             win_hit;

	////////////////////////////////////////////////////////////////////////////
	// Tap selection, one step per channel word back in the chain
	for (genvar k = 0; k < conv_pkg::TAPS; k++) begin : g_tap
		if (k < KERNEL * KERNEL) begin : g_used
			localparam int DIST = ((KERNEL - 1 - k / KERNEL) * IMAGE_WIDTH
				+ (KERNEL - 1 - k % KERNEL)) * CHANNEL_NUM_IN;
			if (DIST == 0) begin : g_new
				// Bottom-right tap is the incoming word
				assign taps_next[k] = pxl_in;
			end else begin : g_old
				assign taps_next[k] = chain[DIST-1];
			end
		end else begin : g_unused
			assign taps_next[k] = '0;
		end
	end

	// Delay chain, newest word at index 0
	always_ff @(posedge clk) begin
		if (pxl_valid) begin
			chain[0] <= pxl_in;
			for (int i = 1; i < CHAIN_LEN; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame position
	assign chan_last = (chan_cnt == CH_W'(CHANNEL_NUM_IN - 1));
	assign col_last  = (col_cnt == COL_W'(IMAGE_WIDTH - 1));
	assign row_last  = (row_cnt == ROW_W'(IMAGE_HEIGHT - 1));
	assign win_hit   = (row_cnt >= ROW_W'(KERNEL - 1)) && (col_cnt >= COL_W'(KERNEL - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			chan_cnt <= '0;
			col_cnt  <= '0;
			row_cnt  <= '0;
		end else if (pxl_valid) begin
			if (chan_last) begin
				chan_cnt <= '0;
				if (col_last) begin
					col_cnt <= '0;
					// Wraps to zero after the final word of a frame
					row_cnt <= row_last ? '0 : row_cnt + 1'b1;
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end else begin
				chan_cnt <= chan_cnt + 1'b1;
			end
		end
	end

	// Window register, one cycle after the word
	always_ff @(posedge clk) begin
		if (pxl_valid) begin
			win.taps    <= taps_next;
			win.channel <= 4'(chan_cnt);
			win.last    <= chan_last && col_last && row_last;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
		end else begin
			win_valid <= pxl_valid && win_hit;
		end
	end

endmodule

// ==== src/conv_mac.sv ====
`timescale 1ns/1ps

module conv_mac #(
	parameter int KERNEL         = 3,
	parameter int CHANNEL_NUM_IN = 2
) (
	input  logic                                                  clk,
	input  logic                                                  reset,
	input  conv_pkg::window_t                                     win,
	input  logic                                                  win_valid,
	input  conv_pkg::weight_t [CHANNEL_NUM_IN*KERNEL*KERNEL-1:0] weights,
	output conv_pkg::acc_t                                        partial,
	output logic                                                  partial_valid,
	output logic                                                  partial_last
);

	localparam int KK = KERNEL * KERNEL;
	// Zero-extended pixel times signed weight
	localparam int PROD_W = 2 * conv_pkg::DATA_WIDTH + 1;

	logic signed [PROD_W-1:0] prod_next [KK];
	logic signed [PROD_W-1:0] prod_q [KK];
	logic                     stage1_valid;
	logic                     stage1_last;
	conv_pkg::acc_t           tree_sum;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1, products against the window's own weight set
	always_comb begin
		for (int k = 0; k < KK; k++) begin
			prod_next[k] = $signed({1'b0, win.taps[k]})
				* $signed(weights[int'(win.channel) * KK + k]);
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid) begin
			prod_q      <= prod_next;
			stage1_last <= win.last;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2, adder tree over the sign-extended products
	always_comb begin
		tree_sum = '0;
		for (int k = 0; k < KK; k++) begin
			tree_sum = tree_sum + conv_pkg::acc_t'(prod_q[k]);
		end
	end

	always_ff @(posedge clk) begin
		if (stage1_valid) begin
			partial      <= tree_sum;
			partial_last <= stage1_last;
		end
	end

	// Valid pipe, a new window may enter every cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			stage1_valid  <= 1'b0;
			partial_valid <= 1'b0;
		end else begin
			stage1_valid  <= win_valid;
			partial_valid <= stage1_valid;
		end
	end

endmodule

// ==== src/conv_channel_adder.sv ====
`timescale 1ns/1ps

module conv_channel_adder #(
	parameter int CHANNEL_NUM_IN = 2
) (
	input  logic             clk,
	input  logic             reset,
	input  conv_pkg::acc_t   partial,
	input  logic             partial_valid,
	input  logic             partial_last,
	output conv_pkg::pixel_t sum_out,
	output logic             sum_valid,
	output logic             frame_end
);

	localparam int CNT_W   = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
	localparam int PXL_MAX = 2 ** conv_pkg::DATA_WIDTH - 1;

	conv_pkg::acc_t   acc;
	conv_pkg::acc_t   total;
	conv_pkg::acc_t   scaled;
	conv_pkg::pixel_t clamped;
	logic [CNT_W-1:0] chan_cnt;
	logic             chan_last;
	logic             sum_done;

	// Running sum including the current partial
	assign total     = acc + partial;
	assign scaled    = total >>> conv_pkg::FRAC_BITS;
	assign chan_last = (chan_cnt == CNT_W'(CHANNEL_NUM_IN - 1));
	assign sum_done  = partial_valid && chan_last;

	// ReLU then saturate to a pixel
	always_comb begin
		if (scaled < 0) begin
			clamped = '0;
		end else if (scaled > conv_pkg::acc_t'(PXL_MAX)) begin
			clamped = '1;
		end else begin
			clamped = scaled[conv_pkg::DATA_WIDTH-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Channel accumulation
	always_ff @(posedge clk) begin
		if (reset) begin
			acc       <= '0;
			chan_cnt  <= '0;
			sum_valid <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			sum_valid <= sum_done;
			frame_end <= sum_done && partial_last;
			if (partial_valid) begin
				acc      <= chan_last ? '0 : total;
				chan_cnt <= chan_last ? '0 : chan_cnt + 1'b1;
			end
		end
	end

	// Result word
	always_ff @(posedge clk) begin
		if (sum_done) begin
			sum_out <= clamped;
		end
	end

endmodule

// ==== src/conv_out_align.sv ====
`timescale 1ns/1ps

module conv_out_align #(
	parameter int ALIGN_DEPTH = 16
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             wr_valid,
	input  conv_pkg::pixel_t wr_data,
	input  logic             frame_end,
	output conv_pkg::pixel_t pxl_out,
	output logic             valid_out
);

	localparam int PTR_W = $clog2(ALIGN_DEPTH);
	localparam int CNT_W = $clog2(ALIGN_DEPTH + 1);

	conv_pkg::pixel_t mem [ALIGN_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             fifo_full;
	logic             fifo_empty;
	logic             wr_en;
	logic             rd_en;
	logic             read_en;

	// Pointer step with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(ALIGN_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign fifo_full  = (count == CNT_W'(ALIGN_DEPTH));
	assign fifo_empty = (count == '0);
	// Overflow words are dropped
	assign wr_en      = wr_valid && !fifo_full;
	assign rd_en      = read_en && !fifo_empty;

	////////////////////////////////////////////////////////////////////////////
	// Storage and read port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
		if (rd_en) begin
			pxl_out <= mem[rd_ptr];
		end
	end

	// Pointers, count, read enable
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			read_en   <= 1'b0;
			valid_out <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky once full or at end of frame
			if (fifo_full || (wr_valid && frame_end)) begin
				read_en <= 1'b1;
			end
			valid_out <= rd_en;
		end
	end

endmodule

// ==== src/conv_layer_top.sv ====
`timescale 1ns/1ps

module conv_layer_top #(
	parameter int KERNEL         = 3,
	parameter int IMAGE_WIDTH    = 6,
	parameter int IMAGE_HEIGHT   = 6,
	parameter int CHANNEL_NUM_IN = 2,
	parameter int ALIGN_DEPTH    = 16
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              pxl_valid,
	input  conv_pkg::pixel_t  pxl_in,
	input  logic              weight_valid,
	input  conv_pkg::weight_t weight_in,
	output logic              weights_ready,
	output conv_pkg::pixel_t  pxl_out,
	output logic              valid_out
);

	conv_pkg::weight_t [CHANNEL_NUM_IN*KERNEL*KERNEL-1:0] weights;
	conv_pkg::window_t win;
	logic              win_valid;
	conv_pkg::acc_t    partial;
	logic              partial_valid;
	logic              partial_last;
	conv_pkg::pixel_t  sum;
	logic              sum_valid;
	logic              frame_end;

	////////////////////////////////////////////////////////////////////////////
	// Weight bank
	conv_weight_regs #(
		.KERNEL        (KERNEL),
		.CHANNEL_NUM_IN(CHANNEL_NUM_IN)
	) weights_i (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_in    (weight_in),
		.weights      (weights),
		.weights_ready(weights_ready)
	);

	// Window forming
	conv_window #(
		.KERNEL        (KERNEL),
		.IMAGE_WIDTH   (IMAGE_WIDTH),
		.IMAGE_HEIGHT  (IMAGE_HEIGHT),
		.CHANNEL_NUM_IN(CHANNEL_NUM_IN)
	) window_i (
		.clk      (clk),
		.reset    (reset),
		.pxl_valid(pxl_valid),
		.pxl_in   (pxl_in),
		.win      (win),
		.win_valid(win_valid)
	);

	// Per-channel multiply and sum
	conv_mac #(
		.KERNEL        (KERNEL),
		.CHANNEL_NUM_IN(CHANNEL_NUM_IN)
	) mac_i (
		.clk          (clk),
		.reset        (reset),
		.win          (win),
		.win_valid    (win_valid),
		.weights      (weights),
		.partial      (partial),
		.partial_valid(partial_valid),
		.partial_last (partial_last)
	);

	// Channel sum, scale, ReLU, saturate
	conv_channel_adder #(
		.CHANNEL_NUM_IN(CHANNEL_NUM_IN)
	) adder_i (
		.clk          (clk),
		.reset        (reset),
		.partial      (partial),
		.partial_valid(partial_valid),
		.partial_last (partial_last),
		.sum_out      (sum),
		.sum_valid    (sum_valid),
		.frame_end    (frame_end)
	);

	// Output alignment FIFO
	conv_out_align #(
		.ALIGN_DEPTH(ALIGN_DEPTH)
	) align_i (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (sum_valid),
		.wr_data  (sum),
		.frame_end(frame_end),
		.pxl_out  (pxl_out),
		.valid_out(valid_out)
	);

endmodule

// ==== verification/conv_layer_asserts.sv ====
`timescale 1ns/1ps

module conv_layer_asserts #(
	parameter int KERNEL = 3,
	parameter int ROW_W  = 3
) (
	input logic             clk,
	input logic             reset,
	input logic             fifo_wr,
	input logic             fifo_full,
	input logic             valid_out,
	input logic             win_valid,
	input logic [ROW_W-1:0] row_cnt
);

	////////////////////////////////////////////////////////////////////////////
	// No write into a full alignment FIFO
	fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
		fifo_wr |-> !fifo_full)
		else $error("alignment FIFO written while full");

	// Output strobe held low while reset is applied
	reset_quiet: assert property (@(posedge clk)
		reset && $past(reset) |-> !valid_out)
		else $error("valid_out high during reset");

	// Window only from a row that holds a full kernel
	// Row of the word is the counter value one clock back
	win_row_ok: assert property (@(posedge clk) disable iff (reset)
		win_valid |-> $past(row_cnt) >= ROW_W'(KERNEL - 1))
		else $error("win_valid for a row above the first full window");

endmodule

bind conv_layer_top conv_layer_asserts #(
	.KERNEL(KERNEL),
	.ROW_W ($clog2(IMAGE_HEIGHT))
) asserts_i (
	.clk      (clk),
	.reset    (reset),
	.fifo_wr  (align_i.wr_valid),
	.fifo_full(align_i.fifo_full),
	.valid_out(valid_out),
	.win_valid(win_valid),
	.row_cnt  (window_i.row_cnt)
);

// ==== verification/conv_layer_tb.sv ====
`timescale 1ns/1ps

module conv_layer_tb;

	////////////////////////////////////////////////////////////////////////////
	// Layer geometry and stim file layout
	localparam int KERNEL       = 3;
	localparam int IMAGE_WIDTH  = 6;
	localparam int IMAGE_HEIGHT = 6;
	localparam int CHANNELS     = 2;
	localparam int WEIGHT_NUM   = CHANNELS * KERNEL * KERNEL;
	localparam int PIXEL_NUM    = CHANNELS * IMAGE_WIDTH * IMAGE_HEIGHT;
	localparam int RESULT_NUM   = (IMAGE_WIDTH - KERNEL + 1) * (IMAGE_HEIGHT - KERNEL + 1);
	// Header of three counts followed by weights, pixels and results
	localparam int FRAME_WORDS  = 3 + WEIGHT_NUM + PIXEL_NUM + RESULT_NUM;
	localparam int STIM_WORDS   = 2 * FRAME_WORDS;
	localparam int CLK_PERIOD   = 100;
	// Two weight loads and three frames over the run
	localparam int DRIVEN_WORDS = 2 * WEIGHT_NUM + 3 * PIXEL_NUM;
	localparam int WATCH_CYCLES = 200 * DRIVEN_WORDS + 500;

	logic              clk;
	logic              reset;
	logic              pxl_valid;
	conv_pkg::pixel_t  pxl_in;
	logic              weight_valid;
	conv_pkg::weight_t weight_in;
	logic              weights_ready;
	conv_pkg::pixel_t  pxl_out;
	logic              valid_out;

	logic [7:0]       stim [STIM_WORDS];
	conv_pkg::pixel_t expected_q [$];
	logic [31:0]      lfsr;
	int               errors;
	int               checks;
	int               out_count;
	logic             frame1_sent;

	conv_layer_top #(
		.KERNEL        (KERNEL),
		.IMAGE_WIDTH   (IMAGE_WIDTH),
		.IMAGE_HEIGHT  (IMAGE_HEIGHT),
		.CHANNEL_NUM_IN(CHANNELS),
		.ALIGN_DEPTH   (16)
	) dut_i (
		.clk          (clk),
		.reset        (reset),
		.pxl_valid    (pxl_valid),
		.pxl_in       (pxl_in),
		.weight_valid (weight_valid),
		.weight_in    (weight_in),
		.weights_ready(weights_ready),
		.pxl_out      (pxl_out),
		.valid_out    (valid_out)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check_value(input string name, input logic [7:0] exp_v,
		input logic [7:0] got);
		checks++;
		assert (got === exp_v) else begin
			errors++;
			$display("ERR t=%0t %s expected %02h got %02h", $time, name, exp_v, got);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("failure at t=%0t: %s", $time, what);
		end
	endtask

	task automatic report(input string name, input int err_mark);
		$display("%s: %s, %0d errors", name, (errors == err_mark) ? "ok" : "failed",
			errors - err_mark);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor sampling mid-cycle
	always @(negedge clk) begin
		if (!reset && valid_out) begin
			out_count++;
			// Read enable must not latch before the first frame end
			check_true(frame1_sent, "valid_out before the first frame was complete");
			if (expected_q.size() == 0) begin
				check_true(1'b0, "valid_out with no result expected");
			end else begin
				check_value("pxl_out", expected_q.pop_front(), pxl_out);
			end
		end
	end

	task automatic check_header(input int base);
		check_true(stim[base] == 8'(WEIGHT_NUM) && stim[base+1] == 8'(PIXEL_NUM)
			&& stim[base+2] == 8'(RESULT_NUM), "stim header does not match the layer size");
	endtask

	task automatic load_weights(input int base);
		for (int i = 0; i < WEIGHT_NUM; i++) begin
			@(negedge clk);
			// Bank incomplete while this load is under way
			if (i > 0) begin
				check_value("weights_ready", 8'h00, {7'b0, weights_ready});
			end
			weight_valid = 1'b1;
			weight_in    = stim[base + 3 + i];
		end
		@(negedge clk);
		weight_valid = 1'b0;
		check_value("weights_ready", 8'h01, {7'b0, weights_ready});
	endtask

	task automatic send_frame(input int base, input bit gaps);
		int pix_base;
		int res_base;
		pix_base = base + 3 + WEIGHT_NUM;
		res_base = pix_base + PIXEL_NUM;
		for (int i = 0; i < RESULT_NUM; i++) begin
			expected_q.push_back(stim[res_base + i]);
		end
		for (int i = 0; i < PIXEL_NUM; i++) begin
			// One LFSR bit per idle decision
			if (gaps) begin
				lfsr = lfsr_next(lfsr);
				while (lfsr[0]) begin
					@(negedge clk);
					pxl_valid = 1'b0;
					lfsr = lfsr_next(lfsr);
				end
			end
			@(negedge clk);
			pxl_valid = 1'b1;
			pxl_in    = stim[pix_base + i];
		end
		@(negedge clk);
		pxl_valid   = 1'b0;
		frame1_sent <= 1'b1;
	endtask

	task automatic finish_frame(input int out_mark);
		while (out_count < out_mark + RESULT_NUM) begin
			@(posedge clk);
		end
		// Short drain so an extra strobe gets counted
		repeat (8) @(posedge clk);
		check_true(out_count == out_mark + RESULT_NUM, "wrong number of valid_out pulses");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		int err_mark;
		int out_mark;
		reset        = 1'b1;
		pxl_valid    = 1'b0;
		pxl_in       = '0;
		weight_valid = 1'b0;
		weight_in    = '0;
		lfsr         = 32'he21b9931;
		errors       = 0;
		checks       = 0;
		out_count    = 0;
		frame1_sent  = 1'b0;
		$readmemh("verification/conv_stim.txt", stim);
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		err_mark = errors;
		check_header(0);
		check_header(FRAME_WORDS);
		check_value("weights_ready", 8'h00, {7'b0, weights_ready});
		load_weights(0);
		report("weight_load", err_mark);

		// Frame 1 back to back
		err_mark = errors;
		out_mark = out_count;
		send_frame(0, 1'b0);
		finish_frame(out_mark);
		report("frame1_no_gaps", err_mark);

		// Same frame with idle gaps
		err_mark = errors;
		out_mark = out_count;
		send_frame(0, 1'b1);
		finish_frame(out_mark);
		report("frame1_with_gaps", err_mark);

		// New weights with ReLU and saturation
		err_mark = errors;
		out_mark = out_count;
		load_weights(FRAME_WORDS);
		send_frame(FRAME_WORDS, 1'b0);
		finish_frame(out_mark);
		report("frame2_relu_saturate", err_mark);

		err_mark = errors;
		check_true(out_count == 3 * RESULT_NUM, "total valid_out count is wrong");
		report("valid_out_count", err_mark);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all results arrived");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== verification/conv_stim.txt ====
// Per frame: header (weight, pixel, result counts), 18 weights channel-major,
// 72 pixels with channels interleaved, then 16 expected outputs in raster order
// Frame 1, gradient image with ramp and Sobel kernels
12 48 10
01 02 03 04 05 06 07 08 09 01 00 ff 02 00 fe 01 00 ff
01 07 03 0c 05 11 07 16 09 1b 0b 20
09 0a 0b 0f 0d 14 0f 19 11 1e 13 23
11 0d 13 12 15 17 17 1c 19 21 1b 26
19 10 1b 15 1d 1a 1f 1f 21 24 23 29
21 13 23 18 25 1d 27 22 29 27 2b 2c
29 16 2b 1b 2d 20 2f 25 31 2a 33 2f
26 2b 31 37 3c 42 47 4d 53 58 5e 64 69 6f 74 7a
// Frame 2, large positive weights on channel 0 and negative weights on channel 1
12 48 10
7f 7f 7f 7f 7f 7f 7f 7f 7f 80 80 80 80 80 80 80 80 80
00 0c 01 0c 02 0c 03 0c 04 0c 05 0c
04 0c 05 0c 06 0c 07 0c 08 0c 09 0c
08 0c 09 0c 0a 0c 0b 0c 0c 0c 0d 0c
0c 0c 0d 0c 0e 0c 0f 0c 10 0c 11 0c
10 0c 11 0c 12 0c 13 0c 14 0c 15 0c
14 0c 15 0c 16 0c 17 0c 18 0c 19 0c
00 00 00 00 00 00 00 00 40 88 cf ff ff ff ff ff

// ==== conv_layer_top.f ====
src/conv_pkg.sv
src/conv_weight_regs.sv
src/conv_window.sv
src/conv_mac.sv
src/conv_channel_adder.sv
src/conv_out_align.sv
src/conv_layer_top.sv
verification/conv_layer_asserts.sv
verification/conv_layer_tb.sv

// ==== Makefile ====
TOP := conv_layer_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f conv_layer_top.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
